//--- source/vend_pkg.sv
package vend_pkg;

    ////////////////////
    // button word
    ////////////////////
    localparam int btn_w        = 12;
    // coin bits, 10 / 5 / 1 units
    localparam int btn_coin_lo  = 0;
    localparam int btn_coin_mid = 1;
    localparam int btn_coin_hi  = 2;
    localparam int btn_return   = 3;
    localparam int btn_down     = 4;
    localparam int btn_add      = 5;
    localparam int btn_select   = 7;
    localparam int btn_buy      = 9;
    localparam int btn_up       = 10;
    localparam int btn_admin    = 11;

    ////////////////////
    // command codes
    ////////////////////
    localparam int cmd_w = 4;
    localparam logic [cmd_w-1:0] cmd_none   = 4'd0;
    localparam logic [cmd_w-1:0] cmd_up     = 4'd1;
    localparam logic [cmd_w-1:0] cmd_down   = 4'd2;
    localparam logic [cmd_w-1:0] cmd_select = 4'd3;
    localparam logic [cmd_w-1:0] cmd_coin1  = 4'd4;
    localparam logic [cmd_w-1:0] cmd_coin5  = 4'd5;
    localparam logic [cmd_w-1:0] cmd_coin10 = 4'd6;
    localparam logic [cmd_w-1:0] cmd_buy    = 4'd7;
    localparam logic [cmd_w-1:0] cmd_return = 4'd8;
    localparam logic [cmd_w-1:0] cmd_add    = 4'd9;
    localparam logic [cmd_w-1:0] cmd_admin  = 4'd10;

    ////////////////////
    // products and money
    ////////////////////
    localparam int prod_n   = 4;
    localparam int pos_w    = 2;
    // 0 means nothing selected
    localparam int item_w   = 3;
    localparam int count_w  = 4;
    localparam int credit_w = 7;
    localparam int money_w  = 8;

    localparam logic [count_w-1:0]  stock_max  = 4'd9;
    localparam logic [count_w-1:0]  init_count [prod_n] = '{4'd9, 4'd1, 4'd0, 4'd4};
    // prices in units of 100 won
    localparam logic [credit_w-1:0] price [prod_n] = '{7'd10, 7'd12, 7'd15, 7'd18};
    localparam logic [credit_w-1:0] credit_max = 7'd99;

    ////////////////////
    // timing
    ////////////////////
    // short values for simulation, board build uses 2000000 and 1000000
    localparam int coin_hold_cycles   = 20;
    localparam int return_step_cycles = 10;
    localparam int hold_w = $clog2(coin_hold_cycles);
    localparam int step_w = $clog2(return_step_cycles);

endpackage

//--- source/button_arbiter.sv
`timescale 1ns/1ps

module button_arbiter import vend_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [btn_w-1:0] button_sw_oneshot,
    output logic [cmd_w-1:0] cmd
);

    logic [btn_w-1:0] btn_q;
    logic [2:0]       coin_bits;
    logic [cmd_w-1:0] cmd_next;

    // 1 unit, 5 units, 10 units from msb to lsb
    assign coin_bits = {btn_q[btn_coin_hi], btn_q[btn_coin_mid], btn_q[btn_coin_lo]};

    ////////////////////
    // fixed priority
    ////////////////////
    always_comb begin
        cmd_next = cmd_none;
        if (btn_q[btn_up]) begin
            cmd_next = cmd_up;
        end else if (btn_q[btn_down]) begin
            cmd_next = cmd_down;
        end else if (btn_q[btn_select]) begin
            cmd_next = cmd_select;
        end else if (coin_bits != 3'b000) begin
            // two coins at once count as nothing
            case (coin_bits)
                3'b100:  cmd_next = cmd_coin1;
                3'b010:  cmd_next = cmd_coin5;
                3'b001:  cmd_next = cmd_coin10;
                default: cmd_next = cmd_none;
            endcase
        end else if (btn_q[btn_buy]) begin
            cmd_next = cmd_buy;
        end else if (btn_q[btn_return]) begin
            cmd_next = cmd_return;
        end else if (btn_q[btn_add]) begin
            cmd_next = cmd_add;
        end else if (btn_q[btn_admin]) begin
            cmd_next = cmd_admin;
        end
    end

    // input stage then command stage
    always_ff @(posedge clk) begin
        if (!rst) begin
            btn_q <= '0;
            cmd   <= cmd_none;
        end else begin
            btn_q <= button_sw_oneshot;
            cmd   <= cmd_next;
        end
    end

    // an idle input word yields an idle command two edges later
    a_idle_cmd: assert property (@(posedge clk) disable iff (!rst)
        (button_sw_oneshot == '0) |-> ##2 (cmd == cmd_none));

endmodule

//--- source/cursor_select.sv
`timescale 1ns/1ps

module cursor_select import vend_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [cmd_w-1:0]  cmd,
    input  logic [prod_n-1:0] empty_mask,
    output logic [pos_w-1:0]  cursor_pos,
    output logic [item_w-1:0] selected_item
);

    logic [item_w-1:0] cursor_item;
    logic [pos_w-1:0]  sel_idx;

    // product id under the cursor, 1 based
    assign cursor_item = item_w'(cursor_pos) + item_w'(1);
    assign sel_idx     = pos_w'(selected_item - item_w'(1));

    ////////////////////
    // cursor
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor_pos <= '0;
        end else begin
            case (cmd)
                cmd_up: begin
                    // top of the list holds
                    if (cursor_pos != '0) begin
                        cursor_pos <= cursor_pos - pos_w'(1);
                    end
                end
                cmd_down: begin
                    if (cursor_pos != pos_w'(prod_n - 1)) begin
                        cursor_pos <= cursor_pos + pos_w'(1);
                    end
                end
                default: begin
                    cursor_pos <= cursor_pos;
                end
            endcase
        end
    end

    ////////////////////
    // selection
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            selected_item <= '0;
        end else begin
            case (cmd)
                cmd_select: begin
                    if (selected_item == cursor_item) begin
                        selected_item <= '0;
                    end else if (!empty_mask[cursor_pos]) begin
                        selected_item <= cursor_item;
                    end
                end
                cmd_buy: begin
                    // ledger decides at this same edge
                    selected_item <= '0;
                end
                default: begin
                    selected_item <= selected_item;
                end
            endcase
        end
    end

    // stock and selection stay consistent across both blocks
    a_no_empty_sel: assert property (@(posedge clk) disable iff (!rst)
        (selected_item != '0) |-> !empty_mask[sel_idx]);

endmodule

//--- source/stock_keeper.sv
`timescale 1ns/1ps

module stock_keeper import vend_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [cmd_w-1:0]   cmd,
    input  logic [pos_w-1:0]   cursor_pos,
    input  logic [item_w-1:0]  selected_item,
    input  logic               vend_pulse,
    output logic [prod_n-1:0]  empty_mask,
    output logic [count_w-1:0] prod_count_current,
    output logic               admin_mode
);

    logic [count_w-1:0] count      [prod_n];
    logic [count_w-1:0] count_next [prod_n];
    logic [pos_w-1:0]   buy_item;
    logic               add_req;

    assign add_req = admin_mode && (cmd == cmd_add);

    ////////////////////
    // next counts
    ////////////////////
    always_comb begin
        for (int i = 0; i < prod_n; i++) begin
            count_next[i] = count[i];
            // restock under the cursor, capped
            if (add_req && (cursor_pos == pos_w'(i)) && (count[i] < stock_max)) begin
                count_next[i] = count_next[i] + count_w'(1);
            end
            if (vend_pulse && (buy_item == pos_w'(i)) && (count[i] != '0)) begin
                count_next[i] = count_next[i] - count_w'(1);
            end
        end
    end

    // look ahead so a vend of the last item blocks a select at the same edge
    always_comb begin
        for (int i = 0; i < prod_n; i++) begin
            empty_mask[i] = (count_next[i] == '0);
        end
    end

    // product being bought, since selection clears before the vend pulse
    always_ff @(posedge clk) begin
        if ((cmd == cmd_buy) && (selected_item != '0)) begin
            buy_item <= pos_w'(selected_item - item_w'(1));
        end
    end

    ////////////////////
    // counts and mode
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < prod_n; i++) begin
                count[i] <= init_count[i];
            end
            // cursor starts on product 1
            prod_count_current <= init_count[0];
            admin_mode         <= 1'b0;
        end else begin
            for (int i = 0; i < prod_n; i++) begin
                count[i] <= count_next[i];
            end
            prod_count_current <= count_next[cursor_pos];
            if (cmd == cmd_admin) begin
                admin_mode <= ~admin_mode;
            end
        end
    end

    for (genvar g = 0; g < prod_n; g++) begin : g_limit
        // restock and vend together never push a count past the limit
        a_count_limit: assert property (@(posedge clk) disable iff (!rst)
            count[g] <= stock_max);
    end

endmodule

//--- source/credit_ledger.sv
`timescale 1ns/1ps

module credit_ledger import vend_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [cmd_w-1:0]   cmd,
    input  logic [item_w-1:0]  selected_item,
    output logic [money_w-1:0] display_money_binary,
    output logic               vend_pulse,
    output logic               deny_pulse,
    output logic               change_pulse,
    output logic               return_busy
);

    logic [credit_w-1:0] credit;
    logic [credit_w-1:0] coin_value;
    logic [credit_w:0]   coin_sum;
    logic [credit_w-1:0] last_coin;
    logic                coin_hold;
    logic [hold_w-1:0]   hold_cnt;
    logic [step_w-1:0]   step_cnt;
    logic [pos_w-1:0]    sel_idx;
    logic                coin_ok;
    logic                buy_req;
    logic                can_pay;
    logic                return_start;

    ////////////////////
    // decode
    ////////////////////
    always_comb begin
        case (cmd)
            cmd_coin1:  coin_value = credit_w'(1);
            cmd_coin5:  coin_value = credit_w'(5);
            cmd_coin10: coin_value = credit_w'(10);
            default:    coin_value = '0;
        endcase
    end

    // coins and buy are locked out while change is paid
    assign coin_ok      = (coin_value != '0) && !return_busy;
    assign coin_sum     = {1'b0, credit} + {1'b0, coin_value};
    assign sel_idx      = pos_w'(selected_item - item_w'(1));
    assign buy_req      = (cmd == cmd_buy) && (selected_item != '0) && !return_busy;
    assign can_pay      = (credit >= price[sel_idx]);
    assign return_start = (cmd == cmd_return) && !return_busy;

    ////////////////////
    // credit and return
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            credit       <= '0;
            vend_pulse   <= 1'b0;
            deny_pulse   <= 1'b0;
            change_pulse <= 1'b0;
            return_busy  <= 1'b0;
            step_cnt     <= '0;
        end else begin
            vend_pulse   <= 1'b0;
            deny_pulse   <= 1'b0;
            change_pulse <= 1'b0;
            if (coin_ok) begin
                // saturate at 99
                if (coin_sum > {1'b0, credit_max}) begin
                    credit <= credit_max;
                end else begin
                    credit <= coin_sum[credit_w-1:0];
                end
            end else if (buy_req) begin
                if (can_pay) begin
                    credit     <= credit - price[sel_idx];
                    vend_pulse <= 1'b1;
                end else begin
                    deny_pulse <= 1'b1;
                end
            end else if (return_start) begin
                return_busy <= 1'b1;
                step_cnt    <= step_w'(return_step_cycles - 1);
            end else if (return_busy) begin
                // one unit of change per step
                if (credit == '0) begin
                    return_busy <= 1'b0;
                end else if (step_cnt == '0) begin
                    credit       <= credit - credit_w'(1);
                    change_pulse <= 1'b1;
                    step_cnt     <= step_w'(return_step_cycles - 1);
                end else begin
                    step_cnt <= step_cnt - step_w'(1);
                end
            end
        end
    end

    ////////////////////
    // coin display hold
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            coin_hold <= 1'b0;
            hold_cnt  <= '0;
        end else if (coin_ok) begin
            coin_hold <= 1'b1;
            hold_cnt  <= hold_w'(coin_hold_cycles - 1);
        end else if (coin_hold) begin
            if (hold_cnt == '0) begin
                coin_hold <= 1'b0;
            end else begin
                hold_cnt <= hold_cnt - hold_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (coin_ok) begin
            last_coin <= coin_value;
        end
    end

    // coin value while held, credit otherwise
    assign display_money_binary = coin_hold ? money_w'(last_coin) : money_w'(credit);

    a_one_result: assert property (@(posedge clk) disable iff (!rst)
        !(vend_pulse && deny_pulse));

endmodule

//--- source/vend_top.sv
`timescale 1ns/1ps

module vend_top import vend_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [btn_w-1:0]   button_sw_oneshot,
    output logic [money_w-1:0] display_money_binary,
    output logic [count_w-1:0] prod_count_current,
    output logic [pos_w-1:0]   cursor_pos,
    output logic [item_w-1:0]  selected_item,
    output logic               admin_mode,
    output logic               vend_pulse,
    output logic               deny_pulse,
    output logic               change_pulse,
    output logic               return_busy
);

    logic [cmd_w-1:0]  cmd;
    logic [prod_n-1:0] empty_mask;

    ////////////////////
    // command path
    ////////////////////
    button_arbiter button_arbiter_inst (
        .clk               (clk),
        .rst               (rst),
        .button_sw_oneshot (button_sw_oneshot),
        .cmd               (cmd)
    );

    ////////////////////
    // product side
    ////////////////////
    cursor_select cursor_select_inst (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .empty_mask    (empty_mask),
        .cursor_pos    (cursor_pos),
        .selected_item (selected_item)
    );

    stock_keeper stock_keeper_inst (
        .clk                (clk),
        .rst                (rst),
        .cmd                (cmd),
        .cursor_pos         (cursor_pos),
        .selected_item      (selected_item),
        .vend_pulse         (vend_pulse),
        .empty_mask         (empty_mask),
        .prod_count_current (prod_count_current),
        .admin_mode         (admin_mode)
    );

    ////////////////////
    // money side
    ////////////////////
    credit_ledger credit_ledger_inst (
        .clk                  (clk),
        .rst                  (rst),
        .cmd                  (cmd),
        .selected_item        (selected_item),
        .display_money_binary (display_money_binary),
        .vend_pulse           (vend_pulse),
        .deny_pulse           (deny_pulse),
        .change_pulse         (change_pulse),
        .return_busy          (return_busy)
    );

endmodule

//--- bench/vend_model.svh
`ifndef vend_model_svh
`define vend_model_svh

// visible machine state, product ids are 1 based in m_sel
int m_cursor;
int m_sel;
int m_count [prod_n];
int m_admin;
int m_credit;

// pulses caused by the last command
int exp_vend;
int exp_deny;
int exp_change;

function automatic void model_reset();
    m_cursor = 0;
    m_sel    = 0;
    m_admin  = 0;
    m_credit = 0;
    for (int i = 0; i < prod_n; i++) begin
        m_count[i] = init_count[i];
    end
endfunction

// up, down, select, coins, buy, return, add, admin
function automatic logic [cmd_w-1:0] decode_buttons(input logic [btn_w-1:0] w);
    logic [2:0] coins;
    coins = {w[btn_coin_hi], w[btn_coin_mid], w[btn_coin_lo]};
    if (w[btn_up]) return cmd_up;
    if (w[btn_down]) return cmd_down;
    if (w[btn_select]) return cmd_select;
    if (coins == 3'b100) return cmd_coin1;
    if (coins == 3'b010) return cmd_coin5;
    if (coins == 3'b001) return cmd_coin10;
    // more than one coin at once is dropped
    if (coins != 3'b000) return cmd_none;
    if (w[btn_buy]) return cmd_buy;
    if (w[btn_return]) return cmd_return;
    if (w[btn_add]) return cmd_add;
    if (w[btn_admin]) return cmd_admin;
    return cmd_none;
endfunction

function automatic void model_apply(input logic [cmd_w-1:0] c, input bit busy);
    int coin;
    exp_vend   = 0;
    exp_deny   = 0;
    exp_change = 0;
    coin = (c == cmd_coin1) ? 1 : (c == cmd_coin5) ? 5 : (c == cmd_coin10) ? 10 : 0;
    case (c)
        cmd_up:   if (m_cursor > 0) m_cursor--;
        cmd_down: if (m_cursor < prod_n - 1) m_cursor++;
        cmd_select: begin
            if (m_sel == m_cursor + 1) m_sel = 0;
            else if (m_count[m_cursor] != 0) m_sel = m_cursor + 1;
        end
        cmd_coin1, cmd_coin5, cmd_coin10: begin
            if (!busy) m_credit = (m_credit + coin > credit_max) ? credit_max : m_credit + coin;
        end
        cmd_buy: begin
            if (m_sel != 0 && !busy) begin
                if (m_credit >= price[m_sel-1]) begin
                    m_credit = m_credit - price[m_sel-1];
                    m_count[m_sel-1]--;
                    exp_vend = 1;
                end else begin
                    exp_deny = 1;
                end
            end
            // selection clears on any buy
            m_sel = 0;
        end
        cmd_return: begin
            if (!busy) begin
                exp_change = m_credit;
                m_credit   = 0;
            end
        end
        cmd_add:   if (m_admin != 0 && m_count[m_cursor] < stock_max) m_count[m_cursor]++;
        cmd_admin: m_admin = (m_admin == 0) ? 1 : 0;
        default:   ;
    endcase
endfunction

`endif

//--- bench/vend_tb.sv
`timescale 1ns/1ps

module vend_tb import vend_pkg::*; ();

    localparam int n_cmds      = 320;
    localparam int n_returns   = 60;
    localparam int idle_cycles = coin_hold_cycles + 4;
    localparam int busy_limit  = 100 * return_step_cycles;
    localparam int watchdog_cycles = n_cmds * (coin_hold_cycles + 10)
                                   + n_returns * busy_limit + 2000;

    logic               clk;
    logic               rst;
    logic [btn_w-1:0]   button_sw_oneshot;
    logic [money_w-1:0] display_money_binary;
    logic [count_w-1:0] prod_count_current;
    logic [pos_w-1:0]   cursor_pos;
    logic [item_w-1:0]  selected_item;
    logic               admin_mode;
    logic               vend_pulse;
    logic               deny_pulse;
    logic               change_pulse;
    logic               return_busy;

    int vend_seen;
    int deny_seen;
    int change_seen;
    int snap_vend;
    int snap_deny;
    int snap_change;
    int value_errors;
    int pulse_errors;
    bit check_pending;
    int btn_list [10] = '{btn_coin_lo, btn_coin_mid, btn_coin_hi, btn_return, btn_down,
                          btn_add, btn_select, btn_buy, btn_up, btn_admin};

    vend_top vend_top_inst (
        .clk                  (clk),
        .rst                  (rst),
        .button_sw_oneshot    (button_sw_oneshot),
        .display_money_binary (display_money_binary),
        .prod_count_current   (prod_count_current),
        .cursor_pos           (cursor_pos),
        .selected_item        (selected_item),
        .admin_mode           (admin_mode),
        .vend_pulse           (vend_pulse),
        .deny_pulse           (deny_pulse),
        .change_pulse         (change_pulse),
        .return_busy          (return_busy)
    );

    `include "vend_model.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the stimulus never finished", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    // pulses are stable across the negative edge
    always @(negedge clk) begin
        if (rst) begin
            if (vend_pulse) vend_seen++;
            if (deny_pulse) deny_seen++;
            if (change_pulse) change_seen++;
        end
    end

    function automatic logic [btn_w-1:0] button_bit(input int idx);
        return btn_w'(1) << idx;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp, act);
        $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
        value_errors++;
    endtask

    task automatic count_pulses(input string name, input int seen, input int expected);
        if (seen < expected) begin
            $display("%0t: %0d %s missing after the last command", $time, expected - seen, name);
            pulse_errors++;
        end
        if (seen > expected) begin
            $display("%0t: %0d extra %s after the last command", $time, seen - expected, name);
            pulse_errors++;
        end
    endtask

    ////////////////////
    // compare process
    ////////////////////
    initial begin
        forever begin
            wait (check_pending);
            if (cursor_pos !== m_cursor) report_mismatch("cursor_pos", m_cursor, cursor_pos);
            if (selected_item !== m_sel) report_mismatch("selected_item", m_sel, selected_item);
            if (prod_count_current !== m_count[m_cursor]) begin
                report_mismatch("prod_count_current", m_count[m_cursor], prod_count_current);
            end
            if (admin_mode !== m_admin) report_mismatch("admin_mode", m_admin, admin_mode);
            if (display_money_binary !== m_credit) begin
                report_mismatch("display_money_binary", m_credit, display_money_binary);
            end
            if (return_busy !== 1'b0) report_mismatch("return_busy", 0, return_busy);
            count_pulses("vend_pulse", vend_seen - snap_vend, exp_vend);
            count_pulses("deny_pulse", deny_seen - snap_deny, exp_deny);
            count_pulses("change_pulse", change_seen - snap_change, exp_change);
            check_pending = 1'b0;
        end
    end

    task automatic request_check();
        check_pending = 1'b1;
        wait (!check_pending);
    endtask

    task automatic take_snapshot();
        snap_vend   = vend_seen;
        snap_deny   = deny_seen;
        snap_change = change_seen;
    endtask

    task automatic drive_button(input logic [btn_w-1:0] word);
        @(posedge clk);
        #1 button_sw_oneshot = word;
        @(posedge clk);
        #1 button_sw_oneshot = '0;
    endtask

    task automatic wait_return_done();
        int waited;
        waited = 0;
        while (return_busy === 1'b1 && waited < busy_limit) begin
            @(negedge clk);
            waited++;
        end
        if (return_busy !== 1'b0) begin
            $display("%0t: return_busy did not fall within %0d cycles", $time, busy_limit);
            pulse_errors++;
        end
        @(negedge clk);
    endtask

    // show holds the expected coin value or -1
    task automatic press(input logic [btn_w-1:0] word, input int show);
        take_snapshot();
        drive_button(word);
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (show >= 0 && display_money_binary !== show) begin
            report_mismatch("display_money_binary", show, display_money_binary);
        end
        repeat (idle_cycles) @(posedge clk);
        @(negedge clk);
        wait_return_done();
        model_apply(decode_buttons(word), 1'b0);
        request_check();
    endtask

    task automatic return_with_coins(input logic [btn_w-1:0] coin_word, input int n);
        int ret_change;
        take_snapshot();
        drive_button(button_bit(btn_return));
        model_apply(cmd_return, 1'b0);
        ret_change = exp_change;
        repeat (4) @(posedge clk);
        for (int k = 0; k < n; k++) begin
            drive_button(coin_word);
            repeat (3) @(posedge clk);
            model_apply(decode_buttons(coin_word), 1'b1);
        end
        @(negedge clk);
        if (return_busy !== 1'b1) begin
            $display("%0t: return ended before the coins were pressed", $time);
            pulse_errors++;
        end
        wait_return_done();
        exp_change = ret_change;
        request_check();
    endtask

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        logic [btn_w-1:0] word;
        void'($urandom(32'h2690a7be));
        rst               = 1'b0;
        button_sw_oneshot = '0;
        check_pending     = 1'b0;
        vend_seen         = 0;
        deny_seen         = 0;
        change_seen       = 0;
        value_errors      = 0;
        pulse_errors      = 0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b1;
        repeat (2) @(negedge clk);
        model_reset();
        model_apply(cmd_none, 1'b0);
        take_snapshot();
        request_check();

        // cursor holds at both ends
        press(button_bit(btn_up), -1);
        repeat (4) press(button_bit(btn_down), -1);
        repeat (4) press(button_bit(btn_up), -1);

        // coins, a double coin, then saturation at 99
        press(button_bit(btn_coin_hi), 1);
        press(button_bit(btn_coin_mid), 5);
        press(button_bit(btn_coin_lo), 10);
        press(button_bit(btn_coin_hi) | button_bit(btn_coin_mid), -1);
        repeat (8) press(button_bit(btn_coin_lo), 10);
        press(button_bit(btn_coin_mid), 5);
        press(button_bit(btn_coin_hi), 1);
        return_with_coins(button_bit(btn_coin_lo), 3);

        // select toggles while empty product 3 stays unselected
        repeat (2) press(button_bit(btn_select), -1);
        repeat (2) press(button_bit(btn_down), -1);
        press(button_bit(btn_select), -1);
        repeat (2) press(button_bit(btn_up), -1);

        // exact price vends and short credit denies
        press(button_bit(btn_coin_lo), 10);
        press(button_bit(btn_select), -1);
        press(button_bit(btn_buy), -1);
        press(button_bit(btn_buy), -1);
        press(button_bit(btn_down), -1);
        press(button_bit(btn_coin_lo), 10);
        press(button_bit(btn_select), -1);
        press(button_bit(btn_buy), -1);
        press(button_bit(btn_coin_mid), 5);
        press(button_bit(btn_select), -1);
        press(button_bit(btn_buy), -1);
        press(button_bit(btn_select), -1);
        press(button_bit(btn_return), -1);

        // restock only in admin mode and never past 9
        press(button_bit(btn_add), -1);
        press(button_bit(btn_admin), -1);
        repeat (10) press(button_bit(btn_add), -1);
        press(button_bit(btn_admin), -1);
        press(button_bit(btn_add), -1);
        press(button_bit(btn_up) | button_bit(btn_buy), -1);
        press(button_bit(btn_buy) | button_bit(btn_return), -1);

        for (int i = 0; i < 200; i++) begin
            word = button_bit(btn_list[$urandom % 10]);
            // sometimes two buttons land in the same cycle
            if ($urandom % 6 == 0) word = word | button_bit(btn_list[$urandom % 10]);
            press(word, -1);
        end

        $display("errors: %0d wrong values, %0d pulse or timing faults",
                 value_errors, pulse_errors);
        if (value_errors + pulse_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+bench
source/vend_pkg.sv
source/button_arbiter.sv
source/cursor_select.sv
source/stock_keeper.sv
source/credit_ledger.sv
source/vend_top.sv
bench/vend_tb.sv
